// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_eth_rx
FILELIST := tb.f
OBJ_DIR  := obj_dir

BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/eth_rx_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_rx_chk (
    input wire                                clk,
    input wire                                rst,
    input wire                                locked,
    input wire [eth_rx_pkg::PORT_W-1:0]       grant,
    input wire                                out_hdr_valid,
    input wire                                out_hdr_ready,
    input wire [eth_rx_pkg::MAC_W-1:0]        out_dest_mac,
    input wire [eth_rx_pkg::MAC_W-1:0]        out_src_mac,
    input wire [eth_rx_pkg::TYPE_W-1:0]       out_eth_type,
    input wire [eth_rx_pkg::PORT_W-1:0]       out_port,
    input wire                                out_pay_tvalid,
    input wire                                out_pay_tready,
    input wire                                out_pay_tlast,
    input wire [eth_rx_pkg::PORT_COUNT-1:0]   hdr_ready,
    input wire [eth_rx_pkg::PORT_COUNT-1:0]   pay_tready
);

    // frame window as seen on the output bus, header accept to last payload byte
    logic                          in_frame;
    logic [eth_rx_pkg::PORT_W-1:0] frame_port;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_frame <= 1'b0;
            frame_port <= '0;
        end else if (out_hdr_valid && out_hdr_ready) begin
            in_frame <= 1'b1;
            frame_port <= out_port;
        end else if (out_pay_tvalid && out_pay_tready && out_pay_tlast) begin
            in_frame <= 1'b0;
        end
    end

    // payload only flows once a header has opened the frame
    pay_in_frame: assert property (@(posedge clk) disable iff (rst)
        out_pay_tvalid |-> in_frame)
        else $error("payload valid outside an accepted frame");

    grant_held: assert property (@(posedge clk) disable iff (rst)
        locked |=> $stable(grant))
        else $error("grant changed during a locked frame");

    // a presented header waits unchanged for its ready
    hdr_stable: assert property (@(posedge clk) disable iff (rst)
        out_hdr_valid && !out_hdr_ready |=> out_hdr_valid && $stable(out_dest_mac) &&
        $stable(out_src_mac) && $stable(out_eth_type) && $stable(out_port))
        else $error("output header dropped or changed before acceptance");

    // header ready only between frames, payload ready only to the open frame's port
    one_ready: assert property (@(posedge clk) disable iff (rst)
        $onehot0({hdr_ready, pay_tready}) && (hdr_ready == '0 || !in_frame) &&
        (pay_tready == '0 || (in_frame && pay_tready[frame_port])))
        else $error("port ready given outside its step of the frame");

endmodule

bind eth_frame_arbiter eth_rx_chk i_chk (
    .clk(clk), .rst(rst), .locked(locked), .grant(grant),
    .out_hdr_valid(out_hdr_valid), .out_hdr_ready(out_hdr_ready),
    .out_dest_mac(out_dest_mac), .out_src_mac(out_src_mac),
    .out_eth_type(out_eth_type), .out_port(out_port),
    .out_pay_tvalid(out_pay_tvalid), .out_pay_tready(out_pay_tready),
    .out_pay_tlast(out_pay_tlast), .hdr_ready(hdr_ready), .pay_tready(pay_tready)
);

`default_nettype wire

// ==== dv/tb_eth_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_eth_rx;

    localparam int NUM_FRAMES = 12;
    localparam int HDR = eth_rx_pkg::ETH_HDR_BYTES;
    localparam int C_PORT = 0;
    localparam int C_LEN = 1;
    localparam int C_EARLY = 2;
    localparam int C_USER = 3;
    localparam int C_GAP = 4;
    localparam int C_STALL = 5;

    // port, bytes, early end, tuser, input gaps, output stalls
    localparam int FRAME_TBL [NUM_FRAMES][6] = '{
        '{0, 20, 0, 0, 0, 0},
        '{1, 18, 0, 1, 0, 0},
        '{0,  9, 1, 0, 0, 0},
        '{1, 15, 0, 0, 0, 0},
        '{0, 30, 0, 1, 1, 0},
        '{1, 14, 1, 0, 1, 0},
        '{1, 25, 0, 0, 1, 1},
        '{0, 16, 0, 0, 0, 1},
        '{1,  1, 1, 1, 0, 0},
        '{0, 40, 0, 1, 1, 1},
        '{1, 33, 0, 0, 1, 1},
        '{0, 22, 0, 0, 0, 0}
    };

    logic                           clk;
    logic                           rst;
    logic [7:0]                     rx_tdata [2];
    logic                           rx_tvalid [2];
    logic                           rx_tlast [2];
    logic                           rx_tuser [2];
    logic                           rx_tready [2];
    logic [1:0]                     rx_busy;
    logic [1:0]                     rx_error;
    logic                           out_hdr_valid;
    logic                           out_hdr_ready;
    logic [eth_rx_pkg::MAC_W-1:0]   out_dest_mac;
    logic [eth_rx_pkg::MAC_W-1:0]   out_src_mac;
    logic [eth_rx_pkg::TYPE_W-1:0]  out_eth_type;
    logic [eth_rx_pkg::PORT_W-1:0]  out_port;
    logic [7:0]                     out_pay_tdata;
    logic                           out_pay_tvalid;
    logic                           out_pay_tlast;
    logic                           out_pay_tuser;
    logic                           out_pay_tready;

    int seed = 32'hc036fb14;

    // header entries carry the table row above the 112 header bits
    logic [119:0] hdr_q0 [$];
    logic [119:0] hdr_q1 [$];
    logic [7:0]   pay_q0 [$];
    logic [7:0]   pay_q1 [$];
    int           hdr_sent [2];
    int           hdr_seen [2];
    int           err_exp [2];
    int           err_seen [2];

    eth_rx_top i_dut (
        .clk(clk), .rst(rst),
        .rx0_tdata(rx_tdata[0]), .rx0_tvalid(rx_tvalid[0]),
        .rx0_tlast(rx_tlast[0]), .rx0_tuser(rx_tuser[0]), .rx0_tready(rx_tready[0]),
        .rx1_tdata(rx_tdata[1]), .rx1_tvalid(rx_tvalid[1]),
        .rx1_tlast(rx_tlast[1]), .rx1_tuser(rx_tuser[1]), .rx1_tready(rx_tready[1]),
        .rx0_busy(rx_busy[0]), .rx1_busy(rx_busy[1]),
        .rx0_error(rx_error[0]), .rx1_error(rx_error[1]),
        .out_hdr_valid(out_hdr_valid), .out_hdr_ready(out_hdr_ready),
        .out_dest_mac(out_dest_mac), .out_src_mac(out_src_mac),
        .out_eth_type(out_eth_type), .out_port(out_port),
        .out_pay_tdata(out_pay_tdata), .out_pay_tvalid(out_pay_tvalid),
        .out_pay_tlast(out_pay_tlast), .out_pay_tuser(out_pay_tuser),
        .out_pay_tready(out_pay_tready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("RESULT: FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic check(input string name, input logic [111:0] got,
                         input logic [111:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got=%0h exp=%0h", $time, name, got, exp);
            fail_run({"value mismatch on ", name});
        end
    endtask

    task automatic pop_hdr(input int p, output logic [119:0] v);
        if ((p == 0 && hdr_q0.size() == 0) || (p != 0 && hdr_q1.size() == 0))
            fail_run($sformatf("header on port %0d with no frame expected", p));
        else if (p == 0)
            v = hdr_q0.pop_front();
        else
            v = hdr_q1.pop_front();
    endtask

    task automatic pop_byte(input int p, output logic [7:0] v);
        if ((p == 0 && pay_q0.size() == 0) || (p != 0 && pay_q1.size() == 0))
            fail_run($sformatf("payload byte on port %0d with none expected", p));
        else if (p == 0)
            v = pay_q0.pop_front();
        else
            v = pay_q1.pop_front();
    endtask

    task automatic send_byte(input int p, input logic [7:0] d, input bit last,
                             input bit user, input bit gaps);
        bit taken;
        while (gaps && ($random(seed) & 3) == 0) begin
            rx_tvalid[p] = 1'b0;
            @(posedge clk);
            #1;
        end
        rx_tdata[p] = d;
        rx_tlast[p] = last;
        rx_tuser[p] = user;
        rx_tvalid[p] = 1'b1;
        // tready is registered, the value seen now is the one at the next edge
        do begin
            taken = rx_tready[p];
            @(posedge clk);
            #1;
        end while (!taken);
        rx_tvalid[p] = 1'b0;
        // mid frame the parser is never idle
        if (!last)
            check($sformatf("rx%0d_busy", p), 112'(rx_busy[p]), 112'(1));
    endtask

    task automatic send_frame(input int p, input int r);
        int           len;
        bit           early;
        bit           user;
        bit           gaps;
        logic [7:0]   d;
        logic [111:0] hdr;
        len = FRAME_TBL[r][C_LEN];
        early = FRAME_TBL[r][C_EARLY] != 0;
        user = FRAME_TBL[r][C_USER] != 0;
        gaps = FRAME_TBL[r][C_GAP] != 0;
        hdr = '0;
        for (int i = 0; i < len; i++) begin
            d = 8'($random(seed));
            // first byte on the wire is the top byte of dest mac
            if (!early && i < HDR)
                hdr = {hdr[103:0], d};
            if (!early && i == HDR - 1) begin
                if (p == 0)
                    hdr_q0.push_back({8'(r), hdr});
                else
                    hdr_q1.push_back({8'(r), hdr});
            end
            if (!early && i >= HDR) begin
                if (p == 0)
                    pay_q0.push_back(d);
                else
                    pay_q1.push_back(d);
            end
            send_byte(p, d, i == len - 1, user, gaps);
            if (!early && i == HDR - 1)
                hdr_sent[p]++;
        end
        if (early)
            err_exp[p]++;
    endtask

    task automatic drive_port(input int p);
        for (int r = 0; r < NUM_FRAMES; r++) begin
            if (FRAME_TBL[r][C_PORT] == p)
                send_frame(p, r);
        end
    endtask

    initial begin
        for (int p = 0; p < 2; p++) begin
            rx_tdata[p] = 8'h00;
            rx_tvalid[p] = 1'b0;
            rx_tlast[p] = 1'b0;
            rx_tuser[p] = 1'b0;
        end
        rst = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        fork
            drive_port(0);
            drive_port(1);
        join
        while (hdr_q0.size() != 0 || hdr_q1.size() != 0 || pay_q0.size() != 0 ||
               pay_q1.size() != 0 || rx_busy != 2'b00) begin
            @(posedge clk);
            #2;
        end
        repeat (4) @(posedge clk);
        #2;
        check("rx0_error pulses", 112'(err_seen[0]), 112'(err_exp[0]));
        check("rx1_error pulses", 112'(err_seen[1]), 112'(err_exp[1]));
        check("rx_busy", 112'(rx_busy), 112'(0));
        $display("RESULT: PASS");
        $finish;
    end

    // output sink and checker
    initial begin : sink
        int           cur_row;
        int           pay_left;
        int           pay_port;
        int           last_port;
        bit           must_switch;
        bit           stall;
        logic [119:0] exp_hdr;
        logic [7:0]   exp_byte;
        cur_row = 0;
        pay_left = 0;
        pay_port = 0;
        last_port = 0;
        must_switch = 1'b0;
        out_hdr_ready = 1'b0;
        out_pay_tready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            // the row of a presented header decides the stall pattern
            if (out_hdr_valid && out_port == 1'b0 && hdr_q0.size() != 0)
                cur_row = int'(hdr_q0[0][119:112]);
            if (out_hdr_valid && out_port == 1'b1 && hdr_q1.size() != 0)
                cur_row = int'(hdr_q1[0][119:112]);
            stall = FRAME_TBL[cur_row][C_STALL] != 0;
            out_hdr_ready = !(stall && ($random(seed) & 1) == 1);
            out_pay_tready = !(stall && ($random(seed) & 1) == 1);
            #1;
            for (int p = 0; p < 2; p++) begin
                if (rx_error[p])
                    err_seen[p]++;
            end
            if (out_hdr_valid && out_hdr_ready) begin
                if (must_switch)
                    check("out_port", 112'(out_port), 112'(1 - last_port));
                must_switch = 1'b0;
                pop_hdr(int'(out_port), exp_hdr);
                cur_row = int'(exp_hdr[119:112]);
                check("out_dest_mac", 112'(out_dest_mac), 112'(exp_hdr[111:64]));
                check("out_src_mac", 112'(out_src_mac), 112'(exp_hdr[63:16]));
                check("out_eth_type", 112'(out_eth_type), 112'(exp_hdr[15:0]));
                pay_left = FRAME_TBL[cur_row][C_LEN] - HDR;
                pay_port = int'(out_port);
                last_port = pay_port;
                hdr_seen[pay_port]++;
            end
            if (out_pay_tvalid && out_pay_tready) begin
                if (pay_left == 0) begin
                    fail_run("payload byte seen outside a frame");
                end else begin
                    check("out_port", 112'(out_port), 112'(pay_port));
                    pop_byte(pay_port, exp_byte);
                    check("out_pay_tdata", 112'(out_pay_tdata), 112'(exp_byte));
                    check("out_pay_tlast", 112'(out_pay_tlast), 112'(pay_left == 1));
                    check("out_pay_tuser", 112'(out_pay_tuser),
                          112'(FRAME_TBL[cur_row][C_USER]));
                    pay_left--;
                    // a header already waiting on the other port must win the next pick
                    if (pay_left == 0)
                        must_switch = hdr_sent[1 - pay_port] > hdr_seen[1 - pay_port];
                end
            end
        end
    end

    initial begin : watchdog
        int total;
        int limit;
        int cycles;
        total = 0;
        for (int r = 0; r < NUM_FRAMES; r++)
            total += FRAME_TBL[r][C_LEN];
        limit = 4 * total + 200;
        cycles = 0;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        fail_run($sformatf("run timed out after %0d cycles", limit));
    end

endmodule

`default_nettype wire

// ==== tb.f ====
verilog/eth_rx_pkg.sv
verilog/eth_rx_parser.sv
verilog/eth_frame_arbiter.sv
verilog/eth_rx_top.sv
dv/eth_rx_chk.sv
dv/tb_eth_rx.sv

// ==== verilog/eth_frame_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_frame_arbiter (
    input  wire                                                 clk,
    input  wire                                                 rst,

    // per port header links
    input  wire  [eth_rx_pkg::PORT_COUNT-1:0]                   hdr_valid,
    output logic [eth_rx_pkg::PORT_COUNT-1:0]                   hdr_ready,
    input  wire  [eth_rx_pkg::PORT_COUNT*eth_rx_pkg::MAC_W-1:0] dest_mac,
    input  wire  [eth_rx_pkg::PORT_COUNT*eth_rx_pkg::MAC_W-1:0] src_mac,
    input  wire  [eth_rx_pkg::PORT_COUNT*eth_rx_pkg::TYPE_W-1:0] eth_type,

    // per port payload links
    input  wire  [eth_rx_pkg::PORT_COUNT*8-1:0]                 pay_tdata,
    input  wire  [eth_rx_pkg::PORT_COUNT-1:0]                   pay_tvalid,
    input  wire  [eth_rx_pkg::PORT_COUNT-1:0]                   pay_tlast,
    input  wire  [eth_rx_pkg::PORT_COUNT-1:0]                   pay_tuser,
    output logic [eth_rx_pkg::PORT_COUNT-1:0]                   pay_tready,

    // shared output bus
    output logic                                                out_hdr_valid,
    input  wire                                                 out_hdr_ready,
    output logic [eth_rx_pkg::MAC_W-1:0]                        out_dest_mac,
    output logic [eth_rx_pkg::MAC_W-1:0]                        out_src_mac,
    output logic [eth_rx_pkg::TYPE_W-1:0]                       out_eth_type,
    output logic [eth_rx_pkg::PORT_W-1:0]                       out_port,
    output logic [7:0]                                          out_pay_tdata,
    output logic                                                out_pay_tvalid,
    output logic                                                out_pay_tlast,
    output logic                                                out_pay_tuser,
    input  wire                                                 out_pay_tready
);

    // grant also remembers the last served port for round robin
    logic [eth_rx_pkg::PORT_W-1:0] grant;
    logic                          grant_valid;
    logic                          locked;
    logic [eth_rx_pkg::PORT_W-1:0] pick;
    logic [eth_rx_pkg::PORT_W-1:0] idx;

    // first requester after the last granted port wins
    always_comb begin
        pick = grant;
        for (int i = eth_rx_pkg::PORT_COUNT; i >= 1; i--) begin
            idx = grant + eth_rx_pkg::PORT_W'(i);
            if (hdr_valid[idx]) begin
                pick = idx;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grant <= '0;
            grant_valid <= 1'b0;
            locked <= 1'b0;
        end else if (!grant_valid) begin
            if (|hdr_valid) begin
                grant <= pick;
                grant_valid <= 1'b1;
            end
        end else if (!locked) begin
            if (out_hdr_valid && out_hdr_ready) begin
                locked <= 1'b1;
            end
        end else if (out_pay_tvalid && out_pay_tready && out_pay_tlast) begin
            // frame done, pick again next cycle
            locked <= 1'b0;
            grant_valid <= 1'b0;
        end
    end

    assign out_hdr_valid = grant_valid & ~locked & hdr_valid[grant];
    assign out_dest_mac  = dest_mac[grant*eth_rx_pkg::MAC_W +: eth_rx_pkg::MAC_W];
    assign out_src_mac   = src_mac[grant*eth_rx_pkg::MAC_W +: eth_rx_pkg::MAC_W];
    assign out_eth_type  = eth_type[grant*eth_rx_pkg::TYPE_W +: eth_rx_pkg::TYPE_W];
    assign out_port      = grant;

    assign out_pay_tvalid = locked & pay_tvalid[grant];
    assign out_pay_tdata  = pay_tdata[grant*8 +: 8];
    assign out_pay_tlast  = pay_tlast[grant];
    assign out_pay_tuser  = pay_tuser[grant];

    // readies only reach the granted port
    always_comb begin
        for (int i = 0; i < eth_rx_pkg::PORT_COUNT; i++) begin
            hdr_ready[i] = grant_valid & ~locked & (grant == eth_rx_pkg::PORT_W'(i)) &
                           out_hdr_ready;
            pay_tready[i] = locked & (grant == eth_rx_pkg::PORT_W'(i)) & out_pay_tready;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/eth_rx_parser.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_rx_parser (
    input  wire                              clk,
    input  wire                              rst,

    // raw frame in
    input  wire  [7:0]                       in_tdata,
    input  wire                              in_tvalid,
    input  wire                              in_tlast,
    input  wire                              in_tuser,
    output logic                             in_tready,

    // parsed header out
    output logic                             hdr_valid,
    input  wire                              hdr_ready,
    output logic [eth_rx_pkg::MAC_W-1:0]     dest_mac,
    output logic [eth_rx_pkg::MAC_W-1:0]     src_mac,
    output logic [eth_rx_pkg::TYPE_W-1:0]    eth_type,

    // payload out
    output logic [7:0]                       pay_tdata,
    output logic                             pay_tvalid,
    output logic                             pay_tlast,
    output logic                             pay_tuser,
    input  wire                              pay_tready,

    // status
    output logic                             busy,
    output logic                             error_header_early_termination
);

    localparam logic [2:0] ST_IDLE     = 3'd0;
    localparam logic [2:0] ST_HEADER   = 3'd1;
    localparam logic [2:0] ST_PAY_IDLE = 3'd2;
    localparam logic [2:0] ST_PAY_XFER = 3'd3;
    localparam logic [2:0] ST_PAY_WAIT = 3'd4;
    localparam logic [2:0] ST_PAY_LAST = 3'd5;

    localparam logic [3:0] LAST_HDR_PTR = 4'(eth_rx_pkg::ETH_HDR_BYTES - 1);

    logic [2:0] state;
    logic [2:0] state_next;
    logic [3:0] ptr;
    logic [3:0] ptr_next;

    logic       in_xfer;
    logic       store_hdr;
    logic       transfer_in_out;
    logic       transfer_in_temp;
    logic       transfer_temp_out;
    logic       hdr_valid_next;
    logic       err_next;

    // whole header, first byte ends up in the top bits
    logic [2*eth_rx_pkg::MAC_W+eth_rx_pkg::TYPE_W-1:0] hdr_shift;

    // skid register behind the output register
    logic [7:0] temp_tdata;
    logic       temp_tlast;
    logic       temp_tuser;

    assign in_xfer = in_tvalid & in_tready;

    assign dest_mac = hdr_shift[eth_rx_pkg::MAC_W+eth_rx_pkg::TYPE_W +: eth_rx_pkg::MAC_W];
    assign src_mac  = hdr_shift[eth_rx_pkg::TYPE_W +: eth_rx_pkg::MAC_W];
    assign eth_type = hdr_shift[0 +: eth_rx_pkg::TYPE_W];

    always_comb begin
        state_next = state;
        ptr_next = ptr;
        store_hdr = 1'b0;
        transfer_in_out = 1'b0;
        transfer_in_temp = 1'b0;
        transfer_temp_out = 1'b0;
        hdr_valid_next = hdr_valid & ~hdr_ready;
        err_next = 1'b0;

        case (state)
            ST_IDLE: begin
                ptr_next = 4'd0;
                if (in_xfer) begin
                    store_hdr = 1'b1;
                    ptr_next = 4'd1;
                    if (in_tlast) begin
                        // one byte frame
                        err_next = 1'b1;
                    end else begin
                        state_next = ST_HEADER;
                    end
                end
            end
            ST_HEADER: begin
                if (in_xfer) begin
                    store_hdr = 1'b1;
                    ptr_next = ptr + 4'd1;
                    if (in_tlast) begin
                        // frame ended with no payload behind the header
                        err_next = 1'b1;
                        state_next = ST_IDLE;
                    end else if (ptr == LAST_HDR_PTR) begin
                        hdr_valid_next = 1'b1;
                        state_next = ST_PAY_IDLE;
                    end
                end
            end
            ST_PAY_IDLE: begin
                // both registers empty
                if (in_xfer) begin
                    transfer_in_out = 1'b1;
                    state_next = in_tlast ? ST_PAY_LAST : ST_PAY_XFER;
                end
            end
            ST_PAY_XFER: begin
                // output register full, skid empty
                if (in_xfer && pay_tready) begin
                    transfer_in_out = 1'b1;
                    state_next = in_tlast ? ST_PAY_LAST : ST_PAY_XFER;
                end else if (pay_tready) begin
                    state_next = ST_PAY_IDLE;
                end else if (in_xfer) begin
                    transfer_in_temp = 1'b1;
                    state_next = ST_PAY_WAIT;
                end
            end
            ST_PAY_WAIT: begin
                // both full, input is held off
                if (pay_tready) begin
                    transfer_temp_out = 1'b1;
                    state_next = temp_tlast ? ST_PAY_LAST : ST_PAY_XFER;
                end
            end
            ST_PAY_LAST: begin
                if (pay_tready) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
            ptr <= 4'd0;
            in_tready <= 1'b0;
            hdr_valid <= 1'b0;
            pay_tvalid <= 1'b0;
            busy <= 1'b0;
            error_header_early_termination <= 1'b0;
        end else begin
            state <= state_next;
            ptr <= ptr_next;
            hdr_valid <= hdr_valid_next;
            error_header_early_termination <= err_next;
            busy <= state_next != ST_IDLE;

            // a new frame waits until the previous header has gone
            in_tready <= (state_next == ST_IDLE) ? ~hdr_valid_next :
                         (state_next == ST_HEADER) || (state_next == ST_PAY_IDLE) ||
                         (state_next == ST_PAY_XFER);
            pay_tvalid <= (state_next == ST_PAY_XFER) || (state_next == ST_PAY_WAIT) ||
                          (state_next == ST_PAY_LAST);
        end
    end

    always_ff @(posedge clk) begin
        if (store_hdr) begin
            hdr_shift <= {hdr_shift[2*eth_rx_pkg::MAC_W+eth_rx_pkg::TYPE_W-9:0], in_tdata};
        end

        if (transfer_in_out) begin
            pay_tdata <= in_tdata;
            pay_tlast <= in_tlast;
            pay_tuser <= in_tuser;
        end else if (transfer_temp_out) begin
            pay_tdata <= temp_tdata;
            pay_tlast <= temp_tlast;
            pay_tuser <= temp_tuser;
        end

        if (transfer_in_temp) begin
            temp_tdata <= in_tdata;
            temp_tlast <= in_tlast;
            temp_tuser <= in_tuser;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/eth_rx_pkg.sv ====
`default_nettype none

package eth_rx_pkg;

    // ethernet header is dest mac, source mac, ethertype
    localparam int ETH_HDR_BYTES = 14;

    // receive ports merged onto the shared output bus
    localparam int PORT_COUNT = 2;

    // width of the port tag on the output
    localparam int PORT_W = 1;

    // header field widths
    localparam int MAC_W = 48;
    localparam int TYPE_W = 16;

endpackage

`default_nettype wire

// ==== verilog/eth_rx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_rx_top (
    input  wire                            clk,
    input  wire                            rst,

    input  wire  [7:0]                     rx0_tdata,
    input  wire                            rx0_tvalid,
    input  wire                            rx0_tlast,
    input  wire                            rx0_tuser,
    output logic                           rx0_tready,

    input  wire  [7:0]                     rx1_tdata,
    input  wire                            rx1_tvalid,
    input  wire                            rx1_tlast,
    input  wire                            rx1_tuser,
    output logic                           rx1_tready,

    output logic                           rx0_busy,
    output logic                           rx1_busy,
    output logic                           rx0_error,
    output logic                           rx1_error,

    output logic                           out_hdr_valid,
    input  wire                            out_hdr_ready,
    output logic [eth_rx_pkg::MAC_W-1:0]   out_dest_mac,
    output logic [eth_rx_pkg::MAC_W-1:0]   out_src_mac,
    output logic [eth_rx_pkg::TYPE_W-1:0]  out_eth_type,
    output logic [eth_rx_pkg::PORT_W-1:0]  out_port,
    output logic [7:0]                     out_pay_tdata,
    output logic                           out_pay_tvalid,
    output logic                           out_pay_tlast,
    output logic                           out_pay_tuser,
    input  wire                            out_pay_tready
);

    // port 0 sits in the low bits of every vector
    logic [eth_rx_pkg::PORT_COUNT-1:0]                    hdr_valid;
    logic [eth_rx_pkg::PORT_COUNT-1:0]                    hdr_ready;
    logic [eth_rx_pkg::PORT_COUNT*eth_rx_pkg::MAC_W-1:0]  dest_mac;
    logic [eth_rx_pkg::PORT_COUNT*eth_rx_pkg::MAC_W-1:0]  src_mac;
    logic [eth_rx_pkg::PORT_COUNT*eth_rx_pkg::TYPE_W-1:0] eth_type;
    logic [eth_rx_pkg::PORT_COUNT*8-1:0]                  pay_tdata;
    logic [eth_rx_pkg::PORT_COUNT-1:0]                    pay_tvalid;
    logic [eth_rx_pkg::PORT_COUNT-1:0]                    pay_tlast;
    logic [eth_rx_pkg::PORT_COUNT-1:0]                    pay_tuser;
    logic [eth_rx_pkg::PORT_COUNT-1:0]                    pay_tready;

    eth_rx_parser i_parser0 (
        .clk(clk), .rst(rst),
        .in_tdata(rx0_tdata), .in_tvalid(rx0_tvalid),
        .in_tlast(rx0_tlast), .in_tuser(rx0_tuser), .in_tready(rx0_tready),
        .hdr_valid(hdr_valid[0]), .hdr_ready(hdr_ready[0]),
        .dest_mac(dest_mac[0 +: eth_rx_pkg::MAC_W]),
        .src_mac(src_mac[0 +: eth_rx_pkg::MAC_W]),
        .eth_type(eth_type[0 +: eth_rx_pkg::TYPE_W]),
        .pay_tdata(pay_tdata[7:0]), .pay_tvalid(pay_tvalid[0]),
        .pay_tlast(pay_tlast[0]), .pay_tuser(pay_tuser[0]), .pay_tready(pay_tready[0]),
        .busy(rx0_busy), .error_header_early_termination(rx0_error)
    );

    eth_rx_parser i_parser1 (
        .clk(clk), .rst(rst),
        .in_tdata(rx1_tdata), .in_tvalid(rx1_tvalid),
        .in_tlast(rx1_tlast), .in_tuser(rx1_tuser), .in_tready(rx1_tready),
        .hdr_valid(hdr_valid[1]), .hdr_ready(hdr_ready[1]),
        .dest_mac(dest_mac[eth_rx_pkg::MAC_W +: eth_rx_pkg::MAC_W]),
        .src_mac(src_mac[eth_rx_pkg::MAC_W +: eth_rx_pkg::MAC_W]),
        .eth_type(eth_type[eth_rx_pkg::TYPE_W +: eth_rx_pkg::TYPE_W]),
        .pay_tdata(pay_tdata[15:8]), .pay_tvalid(pay_tvalid[1]),
        .pay_tlast(pay_tlast[1]), .pay_tuser(pay_tuser[1]), .pay_tready(pay_tready[1]),
        .busy(rx1_busy), .error_header_early_termination(rx1_error)
    );

    eth_frame_arbiter i_arb (
        .clk(clk), .rst(rst),
        .hdr_valid(hdr_valid), .hdr_ready(hdr_ready),
        .dest_mac(dest_mac), .src_mac(src_mac), .eth_type(eth_type),
        .pay_tdata(pay_tdata), .pay_tvalid(pay_tvalid),
        .pay_tlast(pay_tlast), .pay_tuser(pay_tuser), .pay_tready(pay_tready),
        .out_hdr_valid(out_hdr_valid), .out_hdr_ready(out_hdr_ready),
        .out_dest_mac(out_dest_mac), .out_src_mac(out_src_mac),
        .out_eth_type(out_eth_type), .out_port(out_port),
        .out_pay_tdata(out_pay_tdata), .out_pay_tvalid(out_pay_tvalid),
        .out_pay_tlast(out_pay_tlast), .out_pay_tuser(out_pay_tuser),
        .out_pay_tready(out_pay_tready)
    );

endmodule

`default_nettype wire
